// File: hw/cn_regs_pkg.sv
package cn_regs_pkg;

    localparam int WB_ADR_W = 3;   // word address, eight slots
    localparam int WB_DAT_W = 32;

    // host register map, word addresses
    typedef enum logic [WB_ADR_W-1:0] {
        REG_CTRL        = 3'd0,   // bit 0 sim reset, bit 1 buffer replay
        REG_HALF_CNT    = 3'd1,   // tick period minus one
        REG_OFFSET      = 3'd2,   // subtracted from the latched drive
        REG_EXTRA_DRIVE = 3'd3,   // scaled by the button gain
        REG_WAVE_CONST  = 3'd4,   // held sample in constant mode
        REG_WAVE_DATA   = 3'd5,   // write-only, appends one sample
        REG_DRIVE       = 3'd6    // read-only, live drive
    } wb_reg_e;

    // 381 gives the 1 ms tick at real-time speed
    localparam logic [WB_DAT_W-1:0] HALF_CNT_RST = 32'd381;
    localparam logic [1:0]          CTRL_RST     = 2'b00;   // sim running, constant source

endpackage

// File: hw/cn_drive_pkg.sv
package cn_drive_pkg;

    typedef logic [31:0] drive_t;      // unsigned integer current
    typedef logic [2:0]  gain_t;       // button gain, 0..7
    typedef logic [3:0]  prescale_t;   // stepper count before halving

    // neuron compensation on the sensory path
    localparam int SENSORY_SHIFT = 9;
    localparam int EXTRA_SHIFT   = 4;   // applied after the gain multiply

    // last count before the stepper wraps to zero
    localparam prescale_t PRESCALE_MAX = 4'd14;

    typedef enum logic {
        WAVE_CONST_SRC  = 1'b0,   // host constant
        WAVE_BUFFER_SRC = 1'b1    // replay loaded samples
    } wave_src_e;

endpackage

// File: hw/cn_param_regs.sv
`timescale 1ns/1ps

module cn_param_regs (
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic                             i_wb_cyc,
    input  logic                             i_wb_stb,
    input  logic                             i_wb_we,
    input  logic [cn_regs_pkg::WB_ADR_W-1:0] i_wb_adr,
    input  logic [cn_regs_pkg::WB_DAT_W-1:0] i_wb_dat,
    input  cn_drive_pkg::drive_t             i_drive,
    output logic [cn_regs_pkg::WB_DAT_W-1:0] o_wb_dat,
    output logic                             o_wb_ack,
    output logic                             o_sim_reset,
    output cn_drive_pkg::wave_src_e          o_wave_src,
    output cn_drive_pkg::drive_t             o_half_cnt,
    output cn_drive_pkg::drive_t             o_offset,
    output cn_drive_pkg::drive_t             o_extra_drive,
    output cn_drive_pkg::drive_t             o_wave_const,
    output logic                             o_wave_wr,
    output cn_drive_pkg::drive_t             o_wave_wr_data
);
    import cn_regs_pkg::*;
    import cn_drive_pkg::*;

    logic                access;    // new cycle, ack not yet given
    wb_reg_e             reg_sel;
    logic [WB_DAT_W-1:0] rd_mux;

    assign access  = i_wb_cyc && i_wb_stb && !o_wb_ack;   // ack low between accesses
    assign reg_sel = wb_reg_e'(i_wb_adr);

    always_comb begin
        case (reg_sel)
            REG_CTRL:        rd_mux = {{(WB_DAT_W-2){1'b0}}, o_wave_src == WAVE_BUFFER_SRC,
                                       o_sim_reset};
            REG_HALF_CNT:    rd_mux = o_half_cnt;
            REG_OFFSET:      rd_mux = o_offset;
            REG_EXTRA_DRIVE: rd_mux = o_extra_drive;
            REG_WAVE_CONST:  rd_mux = o_wave_const;
            REG_DRIVE:       rd_mux = i_drive;   // live value, not a stored copy
            default:         rd_mux = '0;        // sample reg and unmapped slots
        endcase
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_wb_ack       <= 1'b0;
            o_wb_dat       <= '0;
            o_sim_reset    <= CTRL_RST[0];
            o_wave_src     <= wave_src_e'(CTRL_RST[1]);
            o_half_cnt     <= HALF_CNT_RST;
            o_offset       <= '0;
            o_extra_drive  <= '0;
            o_wave_const   <= '0;
            o_wave_wr      <= 1'b0;
            o_wave_wr_data <= '0;
        end else begin
            o_wb_ack  <= access;
            o_wave_wr <= 1'b0;   // single-cycle strobe
            if (access) begin
                o_wb_dat <= rd_mux;   // captured on every access, meaningful on reads
            end
            if (access && i_wb_we) begin
                case (reg_sel)
                    REG_CTRL: begin
                        o_sim_reset <= i_wb_dat[0];
                        o_wave_src  <= wave_src_e'(i_wb_dat[1]);
                    end
                    REG_HALF_CNT:    o_half_cnt    <= i_wb_dat;
                    REG_OFFSET:      o_offset      <= i_wb_dat;
                    REG_EXTRA_DRIVE: o_extra_drive <= i_wb_dat;
                    REG_WAVE_CONST:  o_wave_const  <= i_wb_dat;
                    REG_WAVE_DATA: begin
                        o_wave_wr      <= 1'b1;   // append one sample
                        o_wave_wr_data <= i_wb_dat;
                    end
                    default: ;   // drive and unmapped slots drop writes
                endcase
            end
        end
    end

endmodule

// File: hw/sim_tick_gen.sv
`timescale 1ns/1ps

module sim_tick_gen (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  logic                 i_sim_reset,
    input  cn_drive_pkg::drive_t i_half_cnt,
    output logic                 o_sim_tick
);
    import cn_drive_pkg::*;

    drive_t cnt;          // cycles left before the next tick
    drive_t half_cnt_q;   // last period seen, for change detect

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cnt        <= '0;
            half_cnt_q <= '0;
            o_sim_tick <= 1'b0;
        end else begin
            half_cnt_q <= i_half_cnt;
            if (i_sim_reset || (i_half_cnt != half_cnt_q)) begin
                cnt        <= i_half_cnt;   // restart a full period
                o_sim_tick <= 1'b0;
            end else if (cnt == '0) begin
                cnt        <= i_half_cnt;   // reload, period is half_cnt + 1
                o_sim_tick <= 1'b1;
            end else begin
                cnt        <= cnt - 1'b1;
                o_sim_tick <= 1'b0;
            end
        end
    end

endmodule

// File: hw/button_gain_stepper.sv
`timescale 1ns/1ps

module button_gain_stepper (
    input  logic                ep50trig,
    input  logic                reset_global,
    input  logic                i_sim_tick,
    input  logic                i_button,
    output cn_drive_pkg::gain_t o_gain
);
    import cn_drive_pkg::*;

    logic      btn_s1;     // first sample flop
    logic      btn_s2;     // second sample, one tick older
    logic      btn_edge;   // level differs between the two samples
    prescale_t prescale;

    assign btn_edge = btn_s1 ^ btn_s2;

    // everything advances on the tick only, so one level change counts once
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_s1   <= 1'b0;
            btn_s2   <= 1'b0;
            prescale <= '0;
        end else if (i_sim_tick) begin
            btn_s1 <= i_button;
            btn_s2 <= btn_s1;
            if (btn_edge) begin
                if (prescale == PRESCALE_MAX) begin
                    prescale <= '0;   // wrap after 14
                end else begin
                    prescale <= prescale + 1'b1;
                end
            end
        end
    end

    // two level changes per gain step
    assign o_gain = prescale[3:1];

endmodule

// File: hw/wave_sample_buffer.sv
`timescale 1ns/1ps

module wave_sample_buffer #(
    parameter int WAVE_DEPTH = 16
) (
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_sim_reset,
    input  logic                    i_sim_tick,
    input  cn_drive_pkg::wave_src_e i_wave_src,
    input  cn_drive_pkg::drive_t    i_wave_const,
    input  logic                    i_wr,
    input  cn_drive_pkg::drive_t    i_wr_data,
    output cn_drive_pkg::drive_t    o_sample
);
    import cn_drive_pkg::*;

    localparam int PTR_W = (WAVE_DEPTH > 1) ? $clog2(WAVE_DEPTH) : 1;

    drive_t           mem [WAVE_DEPTH];   // host samples
    logic [PTR_W-1:0] wr_ptr;             // next slot to load
    logic [PTR_W-1:0] rd_ptr;             // sample presented until the next tick

    // wraps at WAVE_DEPTH, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(WAVE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            for (int i = 0; i < WAVE_DEPTH; i++) begin
                mem[i] <= '0;   // unloaded slots replay as zero
            end
        end else if (i_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_sim_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (i_sim_tick && (i_wave_src == WAVE_BUFFER_SRC)) begin
                rd_ptr <= next_ptr(rd_ptr);   // step after the tick has used it
            end
        end
    end

    assign o_sample = (i_wave_src == WAVE_BUFFER_SRC) ? mem[rd_ptr] : i_wave_const;

endmodule

// File: hw/cn_drive_combiner.sv
`timescale 1ns/1ps

module cn_drive_combiner (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  logic                 i_sim_reset,
    input  logic                 i_sim_tick,
    input  cn_drive_pkg::drive_t i_sensory,
    input  cn_drive_pkg::drive_t i_extra_drive,
    input  cn_drive_pkg::gain_t  i_gain,
    input  cn_drive_pkg::drive_t i_sample,
    input  cn_drive_pkg::drive_t i_offset,
    output cn_drive_pkg::drive_t o_drive,
    output logic                 o_drive_update
);
    import cn_drive_pkg::*;

    drive_t sensory_shifted;   // neuron compensated sensory current
    drive_t extra_scaled;      // extra drive times button gain
    drive_t drive_sum;
    drive_t drive_latch;       // sum held between ticks

    assign sensory_shifted = i_sensory << SENSORY_SHIFT;
    assign extra_scaled    = (i_extra_drive * drive_t'(i_gain)) << EXTRA_SHIFT;
    assign drive_sum       = sensory_shifted + extra_scaled + i_sample;   // wraps mod 2^32

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            drive_latch    <= '0;
            o_drive_update <= 1'b0;
        end else if (i_sim_reset) begin
            drive_latch    <= '0;
            o_drive_update <= 1'b0;
        end else begin
            if (i_sim_tick) begin
                drive_latch <= drive_sum;
            end
            o_drive_update <= i_sim_tick;   // new drive visible this cycle
        end
    end

    // offset is applied after the latch, so offset writes show up at once
    assign o_drive = drive_latch - i_offset;

endmodule

// File: hw/cn_drive_top.sv
`timescale 1ns/1ps

module cn_drive_top #(
    parameter int WAVE_DEPTH = 16
) (
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic                             i_wb_cyc,
    input  logic                             i_wb_stb,
    input  logic                             i_wb_we,
    input  logic [cn_regs_pkg::WB_ADR_W-1:0] i_wb_adr,
    input  logic [cn_regs_pkg::WB_DAT_W-1:0] i_wb_dat,
    output logic [cn_regs_pkg::WB_DAT_W-1:0] o_wb_dat,
    output logic                             o_wb_ack,
    input  cn_drive_pkg::drive_t             i_sensory,
    input  logic                             i_button,
    output cn_drive_pkg::drive_t             o_drive,
    output logic                             o_drive_update,
    output cn_drive_pkg::gain_t              o_gain
);
    import cn_drive_pkg::*;

    logic      sim_reset;    // host controlled, from ctrl bit 0
    logic      sim_tick;     // one-cycle enable per simulated ms
    wave_src_e wave_src;
    drive_t    half_cnt;
    drive_t    offset;
    drive_t    extra_drive;
    drive_t    wave_const;
    logic      wave_wr;
    drive_t    wave_wr_data;
    drive_t    sample;       // waveform current into the sum

    cn_param_regs u_param_regs (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .i_drive        (o_drive),   // drive readback
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .o_sim_reset    (sim_reset),
        .o_wave_src     (wave_src),
        .o_half_cnt     (half_cnt),
        .o_offset       (offset),
        .o_extra_drive  (extra_drive),
        .o_wave_const   (wave_const),
        .o_wave_wr      (wave_wr),
        .o_wave_wr_data (wave_wr_data)
    );

    sim_tick_gen u_tick_gen (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (sim_reset),
        .i_half_cnt   (half_cnt),
        .o_sim_tick   (sim_tick)
    );

    button_gain_stepper u_gain_stepper (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (sim_tick),
        .i_button     (i_button),
        .o_gain       (o_gain)
    );

    wave_sample_buffer #(
        .WAVE_DEPTH (WAVE_DEPTH)
    ) u_wave_buffer (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (sim_reset),
        .i_sim_tick   (sim_tick),
        .i_wave_src   (wave_src),
        .i_wave_const (wave_const),
        .i_wr         (wave_wr),
        .i_wr_data    (wave_wr_data),
        .o_sample     (sample)
    );

    cn_drive_combiner u_combiner (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_sim_reset    (sim_reset),
        .i_sim_tick     (sim_tick),
        .i_sensory      (i_sensory),
        .i_extra_drive  (extra_drive),
        .i_gain         (o_gain),   // same gain that leaves the top
        .i_sample       (sample),
        .i_offset       (offset),
        .o_drive        (o_drive),
        .o_drive_update (o_drive_update)
    );

endmodule

// File: sim/tb_cn_drive.sv
`timescale 1ns/1ps

module tb_cn_drive;
    import cn_regs_pkg::*;
    import cn_drive_pkg::*;

    localparam int TIMEOUT = 2000;   // cycles allowed for any single wait

    logic                ep50trig;
    logic                reset_global;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat;
    logic [WB_DAT_W-1:0] wb_rd_dat;
    logic                wb_ack;
    drive_t              sensory;
    logic                button;
    drive_t              drive;
    logic                drive_update;
    gain_t               gain;

    // reference model state
    drive_t m_half;
    drive_t m_offset;
    drive_t m_extra;
    drive_t m_const;
    drive_t m_sensory;
    int     m_prescale;          // 0..14 and gain is half of it
    drive_t m_samples [16];      // buffer image with unloaded slots zero
    int     m_rd;                // replay slot used at the next tick

    cn_drive_top #(
        .WAVE_DEPTH (16)
    ) i_cn_drive_top (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_wb_cyc       (wb_cyc),
        .i_wb_stb       (wb_stb),
        .i_wb_we        (wb_we),
        .i_wb_adr       (wb_adr),
        .i_wb_dat       (wb_dat),
        .o_wb_dat       (wb_rd_dat),
        .o_wb_ack       (wb_ack),
        .i_sensory      (sensory),
        .i_button       (button),
        .o_drive        (drive),
        .o_drive_update (drive_update),
        .o_gain         (gain)
    );

    initial begin
        ep50trig = 1'b0;
        forever #5 ep50trig = ~ep50trig;   // 100 MHz sim clock
    end

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_drive(input string name, input drive_t got, input drive_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic compare_gain(input string name, input gain_t got, input gain_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%01h expected 0x%01h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic compare_word(input string name, input logic [WB_DAT_W-1:0] got,
                                input logic [WB_DAT_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // expected drive from the model registers and the sample used at the tick
    function automatic drive_t model_drive(input drive_t sample);
        drive_t gain_w;
        gain_w = drive_t'(m_prescale >> 1);
        return (m_sensory << 9) + ((m_extra * gain_w) << 4) + sample - m_offset;
    endfunction

    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(posedge ep50trig);
            #1;
            n++;
            if (n > TIMEOUT) report_timeout("wishbone ack");
        end while (!wb_ack);
        wb_cyc = 1'b0;   // drop the cycle right after the ack
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        @(posedge ep50trig);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_adr = adr;
        wb_dat = dat;
        wait_ack();
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] dat);
        @(posedge ep50trig);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        dat = wb_rd_dat;   // registered and held with the ack
    endtask

    task automatic write_readback(input wb_reg_e adr, input logic [WB_DAT_W-1:0] val,
                                  input string name);
        logic [WB_DAT_W-1:0] rd;
        wb_write(adr, val);
        wb_read(adr, rd);
        compare_word(name, rd, val);
    endtask

    // returns one cycle after the tick edge where drive has settled
    task automatic wait_update(output int cycles);
        cycles = 0;
        do begin
            @(posedge ep50trig);
            #1;
            cycles++;
            if (cycles > TIMEOUT) report_timeout("drive update pulse");
        end while (!drive_update);
    endtask

    initial begin
        int                  cyc;
        int                  n;
        logic [WB_DAT_W-1:0] rd;
        void'($urandom(32'hcc2c_dde5));
        reset_global = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat       = '0;
        sensory      = '0;
        button       = 1'b0;
        m_sensory    = '0;
        m_prescale   = 0;
        m_rd         = 0;
        for (int i = 0; i < 16; i++) begin
            m_samples[i] = '0;
        end
        repeat (4) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;

        // reset state and register defaults
        compare_drive("o_drive", drive, '0);
        compare_gain("o_gain", gain, '0);
        wb_read(REG_CTRL, rd);
        compare_word("ctrl", rd, '0);
        wb_read(REG_HALF_CNT, rd);
        compare_word("half_cnt", rd, 32'd381);
        wb_read(REG_OFFSET, rd);
        compare_word("offset", rd, '0);
        wb_read(REG_EXTRA_DRIVE, rd);
        compare_word("extra_drive", rd, '0);
        wb_read(REG_WAVE_CONST, rd);
        compare_word("wave_const", rd, '0);
        wb_read(REG_DRIVE, rd);
        compare_word("drive readback", rd, '0);

        // random write and readback
        write_readback(REG_CTRL, $urandom_range(0, 3), "ctrl");
        wb_write(REG_CTRL, '0);   // running with the constant source
        write_readback(REG_HALF_CNT, $urandom, "half_cnt");
        m_offset = $urandom;
        write_readback(REG_OFFSET, m_offset, "offset");
        m_extra = $urandom;
        write_readback(REG_EXTRA_DRIVE, m_extra, "extra_drive");
        m_const = $urandom;
        write_readback(REG_WAVE_CONST, m_const, "wave_const");
        wb_read(3'd7, rd);   // unmapped slot
        compare_word("unmapped read", rd, '0);

        // tick spacing
        m_half = $urandom_range(2, 9);
        wb_write(REG_HALF_CNT, m_half);
        wait_update(cyc);   // first pulse after the restart has no defined spacing
        for (int k = 0; k < 3; k++) begin
            wait_update(cyc);
            compare_word("update spacing", cyc, m_half + 1);
        end

        // constant source with random currents
        for (int k = 0; k < 5; k++) begin
            m_sensory = $urandom;
            sensory   = m_sensory;
            m_const   = $urandom;
            wb_write(REG_WAVE_CONST, m_const);
            wait_update(cyc);
            compare_drive("o_drive", drive, model_drive(m_const));
        end
        wb_read(REG_DRIVE, rd);
        compare_word("drive readback", rd, model_drive(m_const));
        m_offset = $urandom;
        wb_write(REG_OFFSET, m_offset);
        compare_drive("o_drive after offset", drive, model_drive(m_const));

        // button steps past the count wrap at 14
        n = $urandom_range(16, 31);
        for (int k = 0; k < n; k++) begin
            button     = ~button;
            m_prescale = (m_prescale == 14) ? 0 : m_prescale + 1;
            repeat (3) wait_update(cyc);   // level held for three ticks
        end
        compare_gain("o_gain", gain, gain_t'(m_prescale >> 1));
        wait_update(cyc);
        compare_drive("o_drive with gain", drive, model_drive(m_const));

        // replay from the buffer
        wb_write(REG_CTRL, 32'd1);   // sim reset clears both pointers
        wb_write(REG_CTRL, 32'd0);
        n = $urandom_range(3, 12);
        for (int i = 0; i < n; i++) begin
            m_samples[i] = $urandom;
            wb_write(REG_WAVE_DATA, m_samples[i]);
        end
        wb_read(REG_WAVE_DATA, rd);   // write-only even with samples loaded
        compare_word("wave_data read", rd, '0);
        wb_write(REG_CTRL, 32'd2);
        for (int k = 0; k < 36; k++) begin   // a bit over two laps
            wait_update(cyc);
            compare_drive("o_drive replay", drive, model_drive(m_samples[m_rd]));
            m_rd = (m_rd + 1) % 16;
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: tb.f
hw/cn_regs_pkg.sv
hw/cn_drive_pkg.sv
hw/cn_param_regs.sv
hw/sim_tick_gen.sv
hw/button_gain_stepper.sv
hw/wave_sample_buffer.sv
hw/cn_drive_combiner.sv
hw/cn_drive_top.sv
sim/tb_cn_drive.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing -f tb.f --top-module tb_cn_drive -Mdir obj_dir
	./obj_dir/Vtb_cn_drive

clean:
	rm -rf obj_dir
